// ==== logic/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int cmd_width     = 12;
  localparam int read_width    = 8;
  localparam int addr_bits_out = 4;  // Opcode plus address, then the line turns around.
  localparam int sclk_half     = 4;  // Core cycles per sclk phase.
  localparam int bit_cnt_width = 4;

  // Command field positions.
  localparam int op_pos   = 11;
  localparam int addr_msb = 10;
  localparam int addr_lsb = 8;
  localparam int data_msb = 7;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_e;

  typedef enum logic [2:0] {
    idle,
    load,
    shift_out,
    shift_in,
    finish
  } shift_state_e;

endpackage

`default_nettype wire

// ==== logic/req_pkg.sv ====
`default_nettype none

package req_pkg;

  localparam int num_req   = 2;
  localparam int rsp_width = 8;

  // Doubles as the bit index into per-requester vectors.
  typedef enum logic {
    req_a = 1'b0,
    req_b = 1'b1
  } req_id_e;

endpackage

`default_nettype wire

// ==== logic/spi_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spi_cmd_if;
  import spi_pkg::*;
  import req_pkg::*;

  logic                 cmd_valid;
  logic                 cmd_ready;
  logic [cmd_width-1:0] cmd;
  logic                 rsp_valid;  // Single-cycle pulse, no ready.
  logic [rsp_width-1:0] rsp_data;

  modport requester (
    output cmd_valid,
    output cmd,
    input  cmd_ready,
    input  rsp_valid,
    input  rsp_data
  );

  modport engine (
    input  cmd_valid,
    input  cmd,
    output cmd_ready,
    output rsp_valid,
    output rsp_data
  );

endinterface

`default_nettype wire

// ==== logic/spi_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_arbiter (
  input  logic         clk,
  input  logic         rst_n,
  spi_cmd_if.engine    a_port,
  spi_cmd_if.engine    b_port,
  spi_cmd_if.requester eng_port
);
  import req_pkg::*;

  req_id_e            last_srv;
  req_id_e            owner;
  req_id_e            pick;
  logic               locked;
  logic               eng_hs;
  logic [num_req-1:0] req_vld;
  logic [num_req-1:0] req_hs;

  assign req_vld = {b_port.cmd_valid, a_port.cmd_valid};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Round-robin choice
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    if (req_vld[req_a] && req_vld[req_b])
      pick = (last_srv == req_a) ? req_b : req_a;  // The one not served last wins.
    else if (req_vld[req_b])
      pick = req_b;
    else
      pick = req_a;
  end

  assign eng_port.cmd_valid = !locked && req_vld[pick];
  assign eng_port.cmd       = (pick == req_a) ? a_port.cmd : b_port.cmd;

  // A port is ready when it would win, or when the other port has nothing pending.
  assign a_port.cmd_ready = !locked && eng_port.cmd_ready &&
                            (pick == req_a || !req_vld[req_b]);
  assign b_port.cmd_ready = !locked && eng_port.cmd_ready &&
                            (pick == req_b || !req_vld[req_a]);

  assign eng_hs = eng_port.cmd_valid && eng_port.cmd_ready;
  assign req_hs = {b_port.cmd_valid && b_port.cmd_ready,
                   a_port.cmd_valid && a_port.cmd_ready};

  // Lock holds from the command handshake until the response pulse.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      locked   <= 1'b0;
      owner    <= req_a;
      last_srv <= req_b;  // So that a wins the first contest.
    end
    else if (eng_hs)
    begin
      locked   <= 1'b1;
      owner    <= pick;
      last_srv <= pick;
    end
    else if (eng_port.rsp_valid)
    begin
      locked <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign a_port.rsp_valid = eng_port.rsp_valid && locked && (owner == req_a);
  assign b_port.rsp_valid = eng_port.rsp_valid && locked && (owner == req_b);
  assign a_port.rsp_data  = eng_port.rsp_data;
  assign b_port.rsp_data  = eng_port.rsp_data;

  // The engine only answers a command this arbiter handed it.
  rsp_while_locked: assert property (@(posedge clk) disable iff (!rst_n)
    eng_port.rsp_valid |-> locked);

  // Two ports never complete a handshake in the same cycle.
  single_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(req_hs));

endmodule

`default_nettype wire

// ==== logic/spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
  input  logic      clk,
  input  logic      rst_n,
  spi_cmd_if.engine host,
  output logic      sclk,
  output logic      cs_n,
  output logic      mosi,
  input  logic      miso
);
  import spi_pkg::*;

  shift_state_e             state;
  spi_op_e                  op;
  logic [cmd_width-1:0]     shreg;
  logic [bit_cnt_width-1:0] div_cnt;
  logic [bit_cnt_width-1:0] bit_cnt;
  logic                     cmd_hs;
  logic                     half_done;
  logic                     last_out;
  logic                     last_in;

  assign host.cmd_ready = (state == idle);
  assign cmd_hs         = host.cmd_valid && host.cmd_ready;
  assign half_done      = (div_cnt == bit_cnt_width'(sclk_half - 1));

  // A write sends the whole word; a read stops after opcode and address.
  assign last_out = (op == op_write) ? (bit_cnt == bit_cnt_width'(cmd_width - 1))
                                     : (bit_cnt == bit_cnt_width'(addr_bits_out - 1));
  assign last_in  = (bit_cnt == bit_cnt_width'(read_width - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control FSM and bus pins
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= idle;
      op      <= op_read;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (cmd_hs)
          begin
            op    <= spi_op_e'(host.cmd[op_pos]);
            state <= load;
          end
        end
        load:
        begin
          cs_n    <= 1'b0;
          mosi    <= shreg[cmd_width-1];  // First bit goes out with chip select.
          div_cnt <= '0;
          bit_cnt <= '0;
          state   <= shift_out;
        end
        shift_out:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            sclk <= ~sclk;
            if (sclk)
            begin
              // Falling edge closes a bit period.
              if (last_out && op == op_write)
              begin
                cs_n  <= 1'b1;
                mosi  <= 1'b0;
                state <= finish;
              end
              else if (last_out)
              begin
                mosi    <= 1'b0;
                bit_cnt <= '0;
                state   <= shift_in;
              end
              else
              begin
                mosi    <= shreg[cmd_width-2];
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
        end
        shift_in:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            sclk <= ~sclk;
            if (sclk && last_in)
            begin
              cs_n  <= 1'b1;
              state <= finish;
            end
            else if (sclk)
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        finish:
        begin
          state <= idle;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  // Shift register holds the command on the way out and the read byte on the way in.
  always_ff @(posedge clk)
  begin
    if (cmd_hs)
      shreg <= host.cmd;
    else if (state == shift_out && half_done && sclk && !last_out)
      shreg <= {shreg[cmd_width-2:0], 1'b0};
    else if (state == shift_in && half_done && !sclk)
      shreg <= {shreg[cmd_width-2:0], miso};  // Sample on rising sclk.
  end

  assign host.rsp_valid = (state == finish);
  assign host.rsp_data  = (op == op_write) ? '0 : shreg[read_width-1:0];

  cs_high_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == idle) |-> cs_n);

  sclk_low_when_deselected: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk);

endmodule

`default_nettype wire

// ==== logic/spi_hub_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_hub_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           a_cmd_valid,
  input  logic [spi_pkg::cmd_width-1:0]  a_cmd,
  output logic                           a_cmd_ready,
  output logic                           a_rsp_valid,
  output logic [req_pkg::rsp_width-1:0]  a_rsp_data,
  input  logic                           b_cmd_valid,
  input  logic [spi_pkg::cmd_width-1:0]  b_cmd,
  output logic                           b_cmd_ready,
  output logic                           b_rsp_valid,
  output logic [req_pkg::rsp_width-1:0]  b_rsp_data,
  output logic                           sclk,
  output logic                           cs_n,
  output logic                           mosi,
  input  logic                           miso
);

  spi_cmd_if a_if ();
  spi_cmd_if b_if ();
  spi_cmd_if eng_if ();

  // Port a onto its channel.
  assign a_if.cmd_valid = a_cmd_valid;
  assign a_if.cmd       = a_cmd;
  assign a_cmd_ready    = a_if.cmd_ready;
  assign a_rsp_valid    = a_if.rsp_valid;
  assign a_rsp_data     = a_if.rsp_data;

  // Port b onto its channel.
  assign b_if.cmd_valid = b_cmd_valid;
  assign b_if.cmd       = b_cmd;
  assign b_cmd_ready    = b_if.cmd_ready;
  assign b_rsp_valid    = b_if.rsp_valid;
  assign b_rsp_data     = b_if.rsp_data;

  spi_arbiter u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .a_port   (a_if.engine),
    .b_port   (b_if.engine),
    .eng_port (eng_if.requester)
  );

  spi_shifter u_shifter (
    .clk   (clk),
    .rst_n (rst_n),
    .host  (eng_if.engine),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

endmodule

`default_nettype wire

// ==== bench/spi_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  regs [0:7] = '{default: 8'h00};
  logic [11:0] rx_shift = '0;
  logic [3:0]  rx_cnt = '0;      // Rising edges seen in this frame.
  logic        wr_op = 1'b0;
  logic [2:0]  addr_r = '0;
  logic [7:0]  tx_shift = '0;
  logic        tx_bit = 1'b0;

  assign miso = tx_bit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Receive on rising sclk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge sclk or posedge cs_n)
  begin
    if (cs_n)
      rx_cnt <= '0;
    else
    begin
      rx_shift <= {rx_shift[10:0], mosi};
      rx_cnt   <= rx_cnt + 4'd1;
      if (rx_cnt == 4'd3)
      begin
        // Opcode and address are complete with this bit.
        wr_op  <= rx_shift[2];
        addr_r <= {rx_shift[1:0], mosi};
      end
      if (rx_cnt == 4'd11 && rx_shift[10])
        regs[rx_shift[9:7]] <= {rx_shift[6:0], mosi};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transmit on falling sclk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge sclk)
  begin
    if (!cs_n && !wr_op)
    begin
      if (rx_cnt == 4'd4)
      begin
        tx_bit   <= regs[addr_r][7];  // The line turns around here.
        tx_shift <= {regs[addr_r][6:0], 1'b0};
      end
      else if (rx_cnt > 4'd4 && rx_cnt < 4'd12)
      begin
        tx_bit   <= tx_shift[7];
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_spi_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_hub;

  localparam int wait_limit = 400;  // Cycles; one transfer takes about a hundred.

  logic        clk = 1'b0;
  logic        rst_n;
  logic        a_cmd_valid;
  logic [11:0] a_cmd;
  logic        a_cmd_ready;
  logic        a_rsp_valid;
  logic [7:0]  a_rsp_data;
  logic        b_cmd_valid;
  logic [11:0] b_cmd;
  logic        b_cmd_ready;
  logic        b_rsp_valid;
  logic [7:0]  b_rsp_data;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;

  logic [7:0]  shadow [0:7] = '{default: 8'h00};
  logic [8:0]  exp_q [$];  // Port in bit 8, data below.
  logic        rsp_log [$];
  logic        in_flight = 1'b0;
  logic [15:0] lfsr = 16'd62;
  int          compare_errors = 0;
  int          check_errors = 0;
  int          timeout_errors = 0;

  spi_hub_top dut (.*);
  spi_slave_model slave (.*);

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference and random source
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};  // Taps 16, 14, 13, 11.
      val  = {val[14:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic logic [7:0] expected_rsp(input logic [11:0] word);
    if (word[11])
      return 8'h00;
    return shadow[word[10:8]];
  endfunction

  task automatic record_cmd(input logic port, input logic [11:0] word);
    exp_q.push_back({port, expected_rsp(word)});
    if (word[11])
      shadow[word[10:8]] = word[7:0];
    in_flight = 1'b1;
  endtask

  task automatic check_response();
    logic       port;
    logic [7:0] got;
    logic [8:0] exp;
    port = b_rsp_valid;
    got  = port ? b_rsp_data : a_rsp_data;
    assert (!(a_rsp_valid && b_rsp_valid) && exp_q.size() > 0)
    else
    begin
      $display("A response pulse arrived with no command outstanding for it.");
      compare_errors++;
      return;
    end
    exp       = exp_q.pop_front();
    in_flight = 1'b0;
    rsp_log.push_back(port);
    assert (exp[8] == port)
    else
    begin
      $display("Response went to port %s, but the command came from the other port.",
               port ? "b" : "a");
      compare_errors++;
    end
    assert (got == exp[7:0])
    else
    begin
      $display("[FAIL] %s_rsp_data: got 0x%02h, expected 0x%02h", port ? "b" : "a",
               got, exp[7:0]);
      compare_errors++;
    end
  endtask

  // Outputs are read before the edge updates them.
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (in_flight)
        assert (!a_cmd_ready && !b_cmd_ready)
        else
        begin
          $display("[FAIL] a_cmd_ready=0x%0h b_cmd_ready=0x%0h during a transfer, expected 0x0",
                   a_cmd_ready, b_cmd_ready);
          compare_errors++;
        end
      if (a_rsp_valid || b_rsp_valid)
        check_response();
      if (a_cmd_valid && a_cmd_ready)
        record_cmd(1'b0, a_cmd);
      if (b_cmd_valid && b_cmd_ready)
        record_cmd(1'b1, b_cmd);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_port(input logic port, input logic valid, input logic [11:0] word);
    if (port)
    begin
      b_cmd_valid = valid;
      b_cmd       = word;
    end
    else
    begin
      a_cmd_valid = valid;
      a_cmd       = word;
    end
  endtask

  task automatic issue_cmd(input logic port, input logic [11:0] word);
    int   waited;
    logic done;
    drive_port(port, 1'b1, word);  // Every caller is on a falling edge here.
    waited = 0;
    done   = 1'b0;
    while (!done && waited < wait_limit)
    begin
      @(posedge clk);
      done = port ? b_cmd_ready : a_cmd_ready;
      waited++;
    end
    @(negedge clk);
    drive_port(port, 1'b0, 12'h000);
    if (!done)
    begin
      $display("Timeout: port %s was never granted the bus.", port ? "b" : "a");
      timeout_errors++;
      return;
    end
    waited = 0;
    done   = 1'b0;
    while (!done && waited < wait_limit)
    begin
      @(posedge clk);
      done = port ? b_rsp_valid : a_rsp_valid;
      waited++;
    end
    @(negedge clk);  // Lets the compare process log the response first.
    if (!done)
    begin
      $display("Timeout: port %s never received its response.", port ? "b" : "a");
      timeout_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_alternation(input int start, input int count, input logic first);
    int i;
    assert (rsp_log.size() == start + count)
    else
    begin
      $display("Expected %0d responses, saw %0d.", count, rsp_log.size() - start);
      check_errors++;
      return;
    end
    for (i = 0; i < count; i++)
      assert (rsp_log[start + i] == (first ^ i[0]))
      else
      begin
        $display("Response %0d of the sequence went to the wrong port.", i);
        check_errors++;
      end
  endtask

  initial
  begin
    logic [15:0] r;
    logic [11:0] word;
    logic        port;
    int          start;
    int          k;
    rst_n       = 1'b0;
    a_cmd_valid = 1'b0;
    a_cmd       = 12'h000;
    b_cmd_valid = 1'b0;
    b_cmd       = 12'h000;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_bit("cs_n", cs_n, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("mosi", mosi, 1'b0);
    check_bit("a_rsp_valid", a_rsp_valid, 1'b0);
    check_bit("b_rsp_valid", b_rsp_valid, 1'b0);
    check_bit("a_cmd_ready", a_cmd_ready, 1'b1);
    check_bit("b_cmd_ready", b_cmd_ready, 1'b1);
    @(negedge clk);

    // Both ports at once; a wins the first contest after reset.
    start = rsp_log.size();
    for (k = 0; k < 4; k++)
      fork
        issue_cmd(1'b0, {1'b1, k[2:0] + 3'd4, 8'h40 + k[7:0]});
        issue_cmd(1'b1, {1'b0, k[2:0] + 3'd4, 8'h00});
      join
    check_alternation(start, 8, 1'b0);

    issue_cmd(1'b0, {1'b1, 3'd1, 8'ha5});
    issue_cmd(1'b0, {1'b0, 3'd1, 8'h00});
    issue_cmd(1'b0, {1'b1, 3'd2, 8'h3c});
    issue_cmd(1'b0, {1'b0, 3'd2, 8'h00});
    issue_cmd(1'b1, {1'b1, 3'd5, 8'h5a});
    issue_cmd(1'b1, {1'b1, 3'd6, 8'hc3});
    issue_cmd(1'b1, {1'b0, 3'd5, 8'h00});
    issue_cmd(1'b1, {1'b0, 3'd6, 8'h00});
    issue_cmd(1'b0, {1'b0, 3'd1, 8'h00});
    issue_cmd(1'b0, {1'b0, 3'd2, 8'h00});

    // b arrives mid-transfer, then competes with a's next command and must win.
    start = rsp_log.size();
    fork
      begin
        issue_cmd(1'b0, {1'b1, 3'd3, 8'h77});
        issue_cmd(1'b0, {1'b0, 3'd3, 8'h00});
      end
      begin
        repeat (6) @(negedge clk);
        issue_cmd(1'b1, {1'b0, 3'd3, 8'h00});
      end
    join
    check_alternation(start, 3, 1'b0);

    for (k = 0; k < 40; k++)
    begin
      r          = take_bits(1);
      port       = r[0];
      r          = take_bits(1);
      word[11]   = r[0];
      r          = take_bits(3);
      word[10:8] = r[2:0];
      r          = take_bits(8);
      word[7:0]  = r[7:0];
      issue_cmd(port, word);
    end

    assert (exp_q.size() == 0)
    else
    begin
      $display("%0d responses never arrived.", exp_q.size());
      check_errors++;
    end
    $display("Errors: compare=%0d check=%0d timeout=%0d", compare_errors, check_errors,
             timeout_errors);
    if (compare_errors + check_errors + timeout_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/spi_pkg.sv
logic/req_pkg.sv
logic/spi_cmd_if.sv
logic/spi_arbiter.sv
logic/spi_shifter.sv
logic/spi_hub_top.sv
bench/spi_slave_model.sv
bench/tb_spi_hub.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_spi_hub
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

SIM_BIN   = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
